// ==== Bender.yml ====
package:
  name: arith_unit

sources:
  - include_dirs:
      - source
    files:
      - source/arith_pkg.sv
      - source/arith_ctrl_if.sv
      - source/arith_ctrl.sv
      - source/step_counter.sv
      - source/sign_fixup.sv
      - source/mult_pipe.sv
      - source/div_core.sv
      - source/arith_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/tb_arith_unit.sv

// ==== source/arith_config.svh ====
`ifndef ARITH_CONFIG_SVH
`define ARITH_CONFIG_SVH

// Operand width of the multiply/divide unit
`define ARITH_WIDTH 16

// Register stages in the magnitude multiplier
`define ARITH_MUL_LATENCY 2

`endif

// ==== source/arith_ctrl.sv ====
`default_nettype none

module arith_ctrl (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  input  arith_pkg::op_e op,
  output logic           busy,
  output logic           done,
  output logic           cnt_load,
  input  logic           cnt_expired,
  arith_ctrl_if.ctrl     cif
);

  arith_pkg::state_e state;
  arith_pkg::state_e state_next;
  logic op_div;
  logic div_q;
  // First cycle of a divide, spent on the zero divisor check
  logic chk;

  assign op_div = (op == arith_pkg::OP_DIVS) || (op == arith_pkg::OP_DIVU);
  assign busy = (state != arith_pkg::ST_IDLE);

  assign cif.load = (state == arith_pkg::ST_IDLE) && start;
  assign cnt_load = cif.load;
  // Follows the incoming opcode while idle so load sees the right operation
  assign cif.is_div = busy ? div_q : op_div;
  assign cif.step = (state == arith_pkg::ST_RUN) && !chk;
  assign cif.finish = (state == arith_pkg::ST_FINISH);

  always_comb begin
    state_next = state;
    case (state)
      arith_pkg::ST_IDLE: begin
        if (start) begin
          state_next = arith_pkg::ST_RUN;
        end
      end
      arith_pkg::ST_RUN: begin
        // Zero divisor leaves right after the check cycle
        if (cif.div_zero || cnt_expired) begin
          state_next = arith_pkg::ST_FINISH;
        end
      end
      arith_pkg::ST_FINISH: begin
        state_next = arith_pkg::ST_IDLE;
      end
      default: begin
        state_next = arith_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= arith_pkg::ST_IDLE;
      div_q <= 1'b0;
      chk <= 1'b0;
      done <= 1'b0;
    end else begin
      state <= state_next;
      chk <= cif.load && op_div;
      done <= cif.finish;
      if (cif.load) begin
        div_q <= op_div;
      end
    end
  end

  // One done pulse per operation
  assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done high for more than one cycle");

  // A load only starts from idle and the unit is busy afterwards
  assert property (@(posedge clk) disable iff (!rst_n) cif.load |-> !busy ##1 busy)
    else $error("load issued while busy");

endmodule

`default_nettype wire

// ==== source/arith_ctrl_if.sv ====
`default_nettype none

interface arith_ctrl_if (
  input logic rst_n
);

  // Capture strobe for all datapaths
  logic load;
  // Current operation is a divide
  logic is_div;
  // Advance one pipeline stage or one divider iteration
  logic step;
  // Register the sign corrected result
  logic finish;
  // Divisor was zero at load
  logic div_zero;

  modport ctrl (
    output load,
    output is_div,
    output step,
    output finish,
    input  div_zero
  );

  modport dp (
    input  rst_n,
    input  load,
    input  is_div,
    input  step,
    input  finish,
    output div_zero
  );

endinterface

`default_nettype wire

// ==== source/arith_pkg.sv ====
`default_nettype none

`include "arith_config.svh"

package arith_pkg;

  typedef logic [`ARITH_WIDTH-1:0] word_t;
  typedef logic [2*`ARITH_WIDTH-1:0] prod_t;

  // Divide opcodes share the upper bit
  typedef enum logic [1:0] {
    OP_MULS,
    OP_MULU,
    OP_DIVS,
    OP_DIVU
  } op_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_FINISH
  } state_e;

endpackage

`default_nettype wire

// ==== source/arith_unit.sv ====
`default_nettype none

module arith_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  input  arith_pkg::op_e   op,
  input  arith_pkg::word_t a,
  input  arith_pkg::word_t b,
  output arith_pkg::word_t result_lo,
  output arith_pkg::word_t result_hi,
  output logic             busy,
  output logic             done
);

  arith_pkg::word_t mag_a;
  arith_pkg::word_t mag_b;
  arith_pkg::word_t quot;
  arith_pkg::word_t rem;
  arith_pkg::prod_t prod;
  logic cnt_load;
  logic cnt_expired;

  arith_ctrl_if cif (
    .rst_n(rst_n)
  );

  arith_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .op         (op),
    .busy       (busy),
    .done       (done),
    .cnt_load   (cnt_load),
    .cnt_expired(cnt_expired),
    .cif        (cif.ctrl)
  );

  step_counter u_cnt (
    .clk    (clk),
    .rst_n  (rst_n),
    .load   (cnt_load),
    .is_div (cif.is_div),
    .expired(cnt_expired)
  );

  // Operand magnitudes in, sign corrected results out
  sign_fixup u_fixup (
    .clk      (clk),
    .op       (op),
    .a        (a),
    .b        (b),
    .mag_a    (mag_a),
    .mag_b    (mag_b),
    .prod     (prod),
    .quot     (quot),
    .rem      (rem),
    .result_lo(result_lo),
    .result_hi(result_hi),
    .cif      (cif.dp)
  );

  mult_pipe u_mult (
    .clk  (clk),
    .mag_a(mag_a),
    .mag_b(mag_b),
    .prod (prod),
    .cif  (cif.dp)
  );

  div_core u_div (
    .clk  (clk),
    .rst_n(rst_n),
    .mag_a(mag_a),
    .mag_b(mag_b),
    .quot (quot),
    .rem  (rem),
    .cif  (cif.dp)
  );

endmodule

`default_nettype wire

// ==== source/div_core.sv ====
`default_nettype none

`include "arith_config.svh"

module div_core (
  input  logic             clk,
  input  logic             rst_n,
  input  arith_pkg::word_t mag_a,
  input  arith_pkg::word_t mag_b,
  output arith_pkg::word_t quot,
  output arith_pkg::word_t rem,
  arith_ctrl_if.dp         cif
);

  localparam int W = `ARITH_WIDTH;

  // Divisor starts aligned to the top bit of the dividend
  logic [2*W-2:0] divisor;
  arith_pkg::word_t mask;
  logic fits;

  assign fits = divisor <= {{(W-1){1'b0}}, rem};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cif.div_zero <= 1'b0;
    end else if (cif.load) begin
      cif.div_zero <= cif.is_div && (mag_b == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (cif.load) begin
      rem <= mag_a;
      divisor <= {mag_b, {(W-1){1'b0}}};
      quot <= '0;
      mask <= {1'b1, {(W-1){1'b0}}};
    end else if (cif.step && cif.is_div) begin
      // Restoring step, subtract only when the shifted divisor fits
      if (fits) begin
        rem <= rem - divisor[W-1:0];
        quot <= quot | mask;
      end
      divisor <= divisor >> 1;
      mask <= mask >> 1;
    end
  end

  // mag_b holds the captured divisor magnitude once load has dropped
  assert property (@(posedge clk) disable iff (!rst_n)
    (cif.finish && cif.is_div && !cif.div_zero) |-> (rem < mag_b))
    else $error("divider remainder not below divisor");

endmodule

`default_nettype wire

// ==== source/mult_pipe.sv ====
`default_nettype none

module mult_pipe (
  input  logic             clk,
  input  arith_pkg::word_t mag_a,
  input  arith_pkg::word_t mag_b,
  output arith_pkg::prod_t prod,
  arith_ctrl_if.dp         cif
);

  // Operand stage
  arith_pkg::word_t op_a;
  arith_pkg::word_t op_b;

  // Both stages hold while step is low
  always_ff @(posedge clk) begin
    if (cif.step) begin
      op_a <= mag_a;
      op_b <= mag_b;
      // Full double width product of the registered operands
      prod <= op_a * op_b;
    end
  end

endmodule

`default_nettype wire

// ==== source/sign_fixup.sv ====
`default_nettype none

`include "arith_config.svh"

module sign_fixup (
  input  logic             clk,
  input  arith_pkg::op_e   op,
  input  arith_pkg::word_t a,
  input  arith_pkg::word_t b,
  output arith_pkg::word_t mag_a,
  output arith_pkg::word_t mag_b,
  input  arith_pkg::prod_t prod,
  input  arith_pkg::word_t quot,
  input  arith_pkg::word_t rem,
  output arith_pkg::word_t result_lo,
  output arith_pkg::word_t result_hi,
  arith_ctrl_if.dp         cif
);

  localparam int MSB = `ARITH_WIDTH - 1;

  logic op_signed;
  arith_pkg::word_t abs_a;
  arith_pkg::word_t abs_b;
  arith_pkg::word_t mag_a_q;
  arith_pkg::word_t mag_b_q;
  logic sign_a_q;
  logic sign_b_q;
  logic signed_q;
  logic div_q;
  logic neg;
  arith_pkg::prod_t prod_fix;
  arith_pkg::word_t quot_fix;
  arith_pkg::word_t rem_mod;
  arith_pkg::word_t rem_fix;

  assign op_signed = (op == arith_pkg::OP_MULS) || (op == arith_pkg::OP_DIVS);
  assign abs_a = (op_signed && a[MSB]) ? -a : a;
  assign abs_b = (op_signed && b[MSB]) ? -b : b;

  // Live magnitudes during load so the divider latches them on the same edge
  assign mag_a = cif.load ? abs_a : mag_a_q;
  assign mag_b = cif.load ? abs_b : mag_b_q;

  always_ff @(posedge clk) begin
    if (cif.load) begin
      mag_a_q <= abs_a;
      mag_b_q <= abs_b;
      sign_a_q <= a[MSB];
      sign_b_q <= b[MSB];
      signed_q <= op_signed;
      div_q <= (op == arith_pkg::OP_DIVS) || (op == arith_pkg::OP_DIVU);
    end
  end

  assign neg = signed_q && (sign_a_q ^ sign_b_q);
  assign prod_fix = neg ? -prod : prod;
  assign quot_fix = neg ? -quot : quot;
  // Remainder ends up with the sign of the divisor
  assign rem_mod = (neg && rem != '0) ? mag_b_q - rem : rem;
  assign rem_fix = (signed_q && sign_b_q) ? -rem_mod : rem_mod;

  always_ff @(posedge clk) begin
    if (!cif.rst_n) begin
      result_lo <= '0;
      result_hi <= '0;
    end else if (cif.finish) begin
      if (cif.div_zero) begin
        result_lo <= '0;
        result_hi <= '0;
      end else if (div_q) begin
        result_lo <= quot_fix;
        result_hi <= rem_fix;
      end else begin
        {result_hi, result_lo} <= prod_fix;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/step_counter.sv ====
`default_nettype none

`include "arith_config.svh"

module step_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  input  logic is_div,
  output logic expired
);

  localparam int CNT_W = $clog2(`ARITH_WIDTH + 1);

  logic [CNT_W-1:0] cnt;
  logic active;

  assign expired = active && (cnt == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
      active <= 1'b0;
    end else if (load) begin
      // Divide counts one cycle more for the zero divisor check
      cnt <= is_div ? CNT_W'(`ARITH_WIDTH) : CNT_W'(`ARITH_MUL_LATENCY - 1);
      active <= 1'b1;
    end else if (expired) begin
      active <= 1'b0;
    end else if (active) begin
      cnt <= cnt - 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) (cnt == '0 && !load) |=> (cnt == '0))
    else $error("step counter wrapped below zero");

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/arith_pkg.sv
source/arith_ctrl_if.sv
source/arith_ctrl.sv
source/step_counter.sv
source/sign_fixup.sv
source/mult_pipe.sv
source/div_core.sv
source/arith_unit.sv
tb/tb_arith_unit.sv

// ==== tb/tb_arith_unit.sv ====
`default_nettype none

`include "arith_config.svh"

module tb_arith_unit;

  localparam int W = `ARITH_WIDTH;
  localparam int NUM_OPS = 300;
  localparam int RESET_CYCLES = 8;
  // Every operation fits in W+4 cycles, plus two reset sequences
  localparam int TIMEOUT_CYCLES = NUM_OPS * (W + 4) + 2 * (RESET_CYCLES + 2);

  logic clk;
  logic rst_n;
  logic start;
  arith_pkg::op_e op;
  arith_pkg::word_t a;
  arith_pkg::word_t b;
  arith_pkg::word_t result_lo;
  arith_pkg::word_t result_hi;
  logic busy;
  logic done;

  logic [15:0] lfsr = 16'd52;
  int cycles = 0;
  int checks = 0;
  int errors = 0;
  // Last result that the DUT reported with done
  arith_pkg::word_t held_lo = '0;
  arith_pkg::word_t held_hi = '0;

  arith_unit UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .op       (op),
    .a        (a),
    .b        (b),
    .result_lo(result_lo),
    .result_hi(result_hi),
    .busy     (busy),
    .done     (done)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: done never arrived within %0d clock cycles", cycles);
      $display("Simulation failed");
      $finish;
    end else begin
      cycles <= cycles + 1;
    end
  end

  // Galois LFSR, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // Reference result from integer arithmetic on the operand values
  task automatic expected_result(input arith_pkg::op_e o, input arith_pkg::word_t x,
                                 input arith_pkg::word_t y, output arith_pkg::word_t lo,
                                 output arith_pkg::word_t hi);
    longint sx;
    longint sy;
    longint p;
    longint q;
    longint r;
    longint mx;
    longint my;
    bit sgn;
    sgn = (o == arith_pkg::OP_MULS) || (o == arith_pkg::OP_DIVS);
    sx = (sgn && x[W-1]) ? longint'(x) - (longint'(1) << W) : longint'(x);
    sy = (sgn && y[W-1]) ? longint'(y) - (longint'(1) << W) : longint'(y);
    if (o == arith_pkg::OP_MULS || o == arith_pkg::OP_MULU) begin
      p = sx * sy;
      lo = p[W-1:0];
      hi = p[2*W-1:W];
    end else if (y == '0) begin
      lo = '0;
      hi = '0;
    end else begin
      mx = (sx < 0) ? -sx : sx;
      my = (sy < 0) ? -sy : sy;
      q = mx / my;
      r = mx % my;
      // Mixed signs: truncated quotient, remainder folded by divisor magnitude
      if ((sx < 0) != (sy < 0)) begin
        q = -q;
        if (r != 0) begin
          r = my - r;
        end
      end
      if (sy < 0) begin
        r = -r;
      end
      lo = q[W-1:0];
      hi = r[W-1:0];
    end
  endtask

  task automatic check_zero_state();
    checks++;
    if (busy !== 1'b0 || done !== 1'b0 || result_lo !== '0 || result_hi !== '0) begin
      errors++;
      $display("ERROR at %0t: after reset busy=%b done=%b hi=%h lo=%h, expected all zero",
               $time, busy, done, result_hi, result_lo);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    start <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_zero_state();
    held_lo = '0;
    held_hi = '0;
  endtask

  task automatic run_op();
    arith_pkg::op_e o;
    arith_pkg::word_t x;
    arith_pkg::word_t y;
    arith_pkg::word_t exp_lo;
    arith_pkg::word_t exp_hi;
    logic [31:0] sel;
    logic [31:0] v;
    int lat;
    int k;
    bit seen;
    draw_bits(2, v);
    o = arith_pkg::op_e'(v[1:0]);
    draw_bits(3, sel);
    draw_bits(W, v);
    x = (sel[2:0] == 3'd0) ? {1'b1, {(W-1){1'b0}}} : v[W-1:0];
    // Corner divisors picked by LFSR bits
    draw_bits(3, sel);
    draw_bits(W, v);
    case (sel[2:0])
      3'd0: y = '0;
      3'd1: y = W'(1);
      3'd2: y = '1;
      3'd3: y = {1'b1, {(W-1){1'b0}}};
      default: y = v[W-1:0];
    endcase
    expected_result(o, x, y, exp_lo, exp_hi);
    if (o == arith_pkg::OP_DIVS || o == arith_pkg::OP_DIVU) begin
      lat = (y == '0) ? 2 : W + 2;
    end else begin
      lat = `ARITH_MUL_LATENCY + 1;
    end

    @(posedge clk);
    start <= 1'b1;
    op <= o;
    a <= x;
    b <= y;
    @(negedge clk);
    checks++;
    if (busy !== 1'b0 || done !== 1'b0 || result_lo !== held_lo || result_hi !== held_hi) begin
      errors++;
      $display("ERROR at %0t: idle state wrong busy=%b done=%b hi=%h lo=%h, held %h %h",
               $time, busy, done, result_hi, result_lo, held_hi, held_lo);
    end
    @(posedge clk);
    start <= 1'b0;

    // k counts rising edges after the start edge
    k = 0;
    seen = 1'b0;
    while (!seen) begin
      @(negedge clk);
      checks++;
      if (done === 1'b1) begin
        seen = 1'b1;
      end else if (busy !== 1'b1 || result_lo !== held_lo || result_hi !== held_hi) begin
        errors++;
        $display("ERROR at %0t: %s running busy=%b hi=%h lo=%h, held %h %h",
                 $time, o.name(), busy, result_hi, result_lo, held_hi, held_lo);
      end
      if (!seen) begin
        // Scramble inputs and throw in starts that must be ignored
        @(posedge clk);
        k++;
        draw_bits(W, v);
        a <= v[W-1:0];
        draw_bits(W, v);
        b <= v[W-1:0];
        draw_bits(2, v);
        op <= arith_pkg::op_e'(v[1:0]);
        draw_bits(1, v);
        start <= v[0] && (k + 2 <= lat);
      end
    end

    checks++;
    if (k != lat || busy !== 1'b0) begin
      errors++;
      $display("ERROR at %0t: %s done after %0d edges with busy=%b, expected %0d edges",
               $time, o.name(), k, busy, lat);
    end
    checks++;
    if (result_lo !== exp_lo || result_hi !== exp_hi) begin
      errors++;
      $display("ERROR at %0t: %s a=%h b=%h got hi=%h lo=%h, expected hi=%h lo=%h",
               $time, o.name(), x, y, result_hi, result_lo, exp_hi, exp_lo);
    end
    held_lo = result_lo;
    held_hi = result_hi;
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    op = arith_pkg::OP_MULS;
    a = '0;
    b = '0;
    apply_reset();
    for (int n = 0; n < NUM_OPS; n++) begin
      // Second reset halfway, with nonzero results held
      if (n == NUM_OPS / 2) begin
        apply_reset();
      end
      run_op();
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
